// File: logic/mam_pkg.sv
/*
 * Shared definitions of the debug memory access module
 *   word, address, strobe and flit widths
 *   flit and memory request structs
 *   packet format constants and counter limits
 *   control state and emitter mode enums
 */
`default_nettype none

package mam_pkg;

   localparam int FLIT_W         = 16;
   localparam int DATA_W         = 32;
   localparam int ADDR_W         = 32;
   localparam int STRB_W         = DATA_W / 8;
   localparam int HALVES         = DATA_W / FLIT_W;  // Flits per word
   localparam int ADDR_FLITS     = ADDR_W / FLIT_W;
   localparam int BEATS_W        = 13;
   localparam int HDR_FLITS      = 3;                // Dest, src, flags
   localparam int PKT_DATA_FLITS = 4;

   // Type event, subtype 0, rest reserved
   localparam logic [FLIT_W-1:0] EVENT_FLAGS = {2'b10, 4'b0000, 10'h000};

   localparam int HALF_W     = $clog2(HALVES);
   localparam int ADDR_CNT_W = $clog2(ADDR_FLITS);
   localparam int HDR_CNT_W  = $clog2(HDR_FLITS);
   localparam int PKT_CNT_W  = $clog2(PKT_DATA_FLITS);

   localparam logic [HALF_W-1:0]     HALF_LAST = HALF_W'(HALVES - 1);
   localparam logic [ADDR_CNT_W-1:0] ADDR_LAST = ADDR_CNT_W'(ADDR_FLITS - 1);
   localparam logic [HDR_CNT_W-1:0]  HDR_LAST  = HDR_CNT_W'(HDR_FLITS - 1);
   localparam logic [PKT_CNT_W-1:0]  PKT_LAST  = PKT_CNT_W'(PKT_DATA_FLITS - 1);

   typedef struct packed {
      logic              valid;
      logic              last;
      logic [FLIT_W-1:0] data;
   } mam_flit_t;

   typedef struct packed {
      logic               we;
      logic               burst;
      logic               sync;   // Acknowledge after write_complete
      logic [ADDR_W-1:0]  addr;
      logic [BEATS_W-1:0] beats;
      logic [STRB_W-1:0]  strb;
   } mam_req_t;

   typedef enum logic [3:0] {
      ST_IDLE, ST_HEADER, ST_ADDRESS, ST_REQUEST, ST_WRITE_SKIP, ST_WRITE,
      ST_WRITE_WAIT, ST_SYNC_WAIT, ST_SYNC_PACKET, ST_READ_HEADER, ST_READ_DATA
   } mam_state_e;

   typedef enum logic [1:0] {
      EMIT_NONE, EMIT_EVENT, EMIT_READ_HDR, EMIT_READ_DATA
   } mam_emit_e;

endpackage

`default_nettype wire

// File: logic/mam_req_capture.sv
/*
 * Request capture
 *   stores the requester source id
 *   decodes the command flit into the memory request
 *   shifts in the address flits, upper half first
 */
`timescale 1ns/100ps
`default_nettype none

module mam_req_capture
   import mam_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire mam_flit_t   in,
   input  wire logic        src_load,
   input  wire logic        hdr_load,
   input  wire logic        addr_load,
   output mam_req_t         req,
   output logic [15:0]      di_src,
   output logic             addr_done
);

   logic [ADDR_CNT_W-1:0] addr_cnt;

   assign addr_done = addr_load && (addr_cnt == ADDR_LAST);

   always_ff @(posedge clk) begin
      if (rst) begin
         addr_cnt <= '0;
      end else if (addr_load) begin
         addr_cnt <= addr_done ? '0 : addr_cnt + 1'b1;
      end
   end

   // Payload registers, only written on their strobes
   always_ff @(posedge clk) begin
      if (src_load) begin
         di_src <= in.data;
      end
      if (hdr_load) begin
         req.we    <= in.data[15];
         req.burst <= in.data[14];
         req.sync  <= in.data[13];
         req.strb  <= in.data[STRB_W-1:0];
         // Single access is always one beat
         req.beats <= in.data[14] ? BEATS_W'(in.data[7:0]) : BEATS_W'(1);
      end
      if (addr_load) begin
         req.addr <= {req.addr[ADDR_W-FLIT_W-1:0], in.data}; // Upper half arrives first
      end
   end

endmodule

`default_nettype wire

// File: logic/mam_write_gather.sv
/*
 * Write data gather
 *   places accepted data flits into their half of a word
 *   presents the full word in the cycle its last half arrives
 */
`timescale 1ns/100ps
`default_nettype none

module mam_write_gather
   import mam_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire mam_flit_t          in,
   input  wire logic               gather_en,
   output logic [DATA_W-1:0]       write_data,
   output logic                    word_full
);

   logic [HALF_W-1:0] half_cnt;
   logic [DATA_W-1:0] word_q;
   logic [DATA_W-1:0] word_next;

   // Big endian, half 0 is the upper flit
   always_comb begin
      word_next = word_q;
      word_next[(HALVES - 1 - int'(half_cnt)) * FLIT_W +: FLIT_W] = in.data;
   end

   assign word_full  = gather_en && (half_cnt == HALF_LAST);
   assign write_data = word_full ? word_next : word_q; // Held in word_q while stalled

   always_ff @(posedge clk) begin
      if (rst) begin
         half_cnt <= '0;
      end else if (gather_en) begin
         half_cnt <= word_full ? '0 : half_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (gather_en) begin
         word_q <= word_next;
      end
   end

endmodule

`default_nettype wire

// File: logic/mam_read_emitter.sv
/*
 * Outgoing packet emitter
 *   header flits of event and read response packets
 *   read data flits, upper half of each word first
 *   last flag at packet end or at the final half of the read
 */
`timescale 1ns/100ps
`default_nettype none

module mam_read_emitter
   import mam_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire mam_emit_e          mode,
   input  wire logic [15:0]        di_src,
   input  wire logic [15:0]        id,
   input  wire logic [DATA_W-1:0]  read_data,
   input  wire logic               last_beat,
   input  wire logic               out_ready,
   output mam_flit_t               out,
   output logic                    flit_taken,
   output logic                    word_taken,
   output logic                    pkt_end
);

   logic [HDR_CNT_W-1:0] hdr_cnt;
   logic [PKT_CNT_W-1:0] data_cnt; // Data flits in current packet
   logic [HALF_W-1:0]    half_cnt;
   logic                 hdr_mode;

   assign hdr_mode = (mode == EMIT_EVENT) || (mode == EMIT_READ_HDR);

   always_comb begin
      out = '0;
      if (hdr_mode) begin
         out.valid = 1'b1;
         if (hdr_cnt == '0) begin
            out.data = di_src;       // Reply to requester
         end else if (hdr_cnt == HDR_CNT_W'(1)) begin
            out.data = id;
         end else begin
            out.data = EVENT_FLAGS;
            out.last = (mode == EMIT_EVENT); // Sync ack is header only
         end
      end else if (mode == EMIT_READ_DATA) begin
         out.valid = 1'b1;
         out.data  = read_data[(HALVES - 1 - int'(half_cnt)) * FLIT_W +: FLIT_W];
         out.last  = (data_cnt == PKT_LAST) || ((half_cnt == HALF_LAST) && last_beat);
      end
   end

   assign flit_taken = out.valid && out_ready;
   assign word_taken = flit_taken && (mode == EMIT_READ_DATA) && (half_cnt == HALF_LAST);

   // Also marks the end of a read header, so control can move on to the data
   assign pkt_end = flit_taken && (out.last || (hdr_mode && hdr_cnt == HDR_LAST));

   always_ff @(posedge clk) begin
      if (rst) begin
         hdr_cnt  <= '0;
         data_cnt <= '0;
         half_cnt <= '0;
      end else if (flit_taken) begin
         if (hdr_mode) begin
            hdr_cnt <= (hdr_cnt == HDR_LAST) ? '0 : hdr_cnt + 1'b1;
         end else begin
            half_cnt <= (half_cnt == HALF_LAST) ? '0 : half_cnt + 1'b1;
            data_cnt <= out.last ? '0 : data_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/mam_ctrl.sv
/*
 * Access control FSM
 *   request header and address capture
 *   write beats across continuation packets
 *   read response packets and sync acknowledge
 *   remaining beat count and memory handshakes
 */
`timescale 1ns/100ps
`default_nettype none

module mam_ctrl
   import mam_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      in_valid,
   input  wire logic      in_last,
   output logic           in_ready,
   input  wire mam_req_t  req,
   input  wire logic      addr_done,
   input  wire logic      word_full,
   input  wire logic      flit_taken,
   input  wire logic      word_taken,
   input  wire logic      pkt_end,
   output logic           src_load,
   output logic           hdr_load,
   output logic           addr_load,
   output logic           gather_en,
   output mam_emit_e      mode,
   output logic           last_beat,
   output logic           req_valid,
   input  wire logic      req_ready,
   output logic           write_valid,
   input  wire logic      write_ready,
   input  wire logic      write_complete,
   input  wire logic      read_valid,
   output logic           read_ready
);

   mam_state_e           state;
   mam_state_e           done_state;  // Where a finished write goes
   logic [BEATS_W-1:0]   beats_left;
   logic [HDR_CNT_W-1:0] skip_cnt;    // Header flits, also continuation headers
   logic                 in_pkt;      // Data still follows in this packet
   logic                 last_addr;   // Address flit ended the packet
   logic                 in_take;

   assign in_ready = state inside {ST_IDLE, ST_HEADER, ST_ADDRESS, ST_WRITE_SKIP, ST_WRITE};
   assign in_take  = in_valid && in_ready;

   assign src_load  = (state == ST_HEADER) && in_valid && (skip_cnt == '0);
   assign hdr_load  = (state == ST_HEADER) && in_valid && (skip_cnt == HDR_LAST);
   assign addr_load = (state == ST_ADDRESS) && in_valid;
   assign gather_en = (state == ST_WRITE) && in_valid;

   assign last_beat   = (beats_left == BEATS_W'(1));
   assign req_valid   = (state == ST_REQUEST);
   assign write_valid = word_full || (state == ST_WRITE_WAIT);
   assign read_ready  = (state == ST_READ_DATA) && word_taken;

   always_comb begin
      case (state)
         ST_SYNC_PACKET: mode = EMIT_EVENT;
         ST_READ_HEADER: mode = EMIT_READ_HDR;
         ST_READ_DATA:   mode = read_valid ? EMIT_READ_DATA : EMIT_NONE;
         default:        mode = EMIT_NONE;
      endcase
   end

   always_comb begin
      done_state = ST_IDLE;
      if (req.sync) begin
         done_state = write_complete ? ST_SYNC_PACKET : ST_SYNC_WAIT;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ST_IDLE;
         beats_left <= '0;
         skip_cnt   <= '0;
         in_pkt     <= 1'b0;
         last_addr  <= 1'b0;
      end else begin
         if (in_take && (state == ST_HEADER || state == ST_WRITE_SKIP)) begin
            skip_cnt <= (skip_cnt == HDR_LAST) ? '0 : skip_cnt + 1'b1;
         end
         case (state)
            ST_IDLE: if (in_take) state <= ST_HEADER;      // Destination flit
            ST_HEADER: if (in_take && skip_cnt == HDR_LAST) state <= ST_ADDRESS;
            ST_ADDRESS: begin
               if (addr_done) begin
                  last_addr <= in_last;
                  state     <= ST_REQUEST;
               end
            end
            ST_REQUEST: begin
               if (req_ready) begin
                  beats_left <= req.beats;
                  if (!req.we) state <= ST_READ_HEADER;
                  else if (last_addr) state <= ST_WRITE_SKIP;
                  else state <= ST_WRITE;
               end
            end
            ST_WRITE_SKIP: if (in_take && skip_cnt == HDR_LAST) state <= ST_WRITE;
            ST_WRITE: begin
               if (word_full && !write_ready) begin
                  in_pkt <= !in_last;
                  state  <= ST_WRITE_WAIT;
               end else if (word_full) begin
                  beats_left <= beats_left - 1'b1;
                  if (last_beat) state <= done_state;
                  else if (in_last) state <= ST_WRITE_SKIP;
               end else if (in_valid && in_last) begin
                  state <= ST_WRITE_SKIP;   // Word continues in next packet
               end
            end
            ST_WRITE_WAIT: begin
               if (write_ready) begin
                  beats_left <= beats_left - 1'b1;
                  if (last_beat) state <= done_state;
                  else if (in_pkt) state <= ST_WRITE;
                  else state <= ST_WRITE_SKIP;
               end
            end
            ST_SYNC_WAIT: if (write_complete) state <= ST_SYNC_PACKET;
            ST_SYNC_PACKET: if (pkt_end) state <= ST_IDLE;
            ST_READ_HEADER: if (pkt_end) state <= ST_READ_DATA;
            ST_READ_DATA: begin
               if (word_taken) begin
                  beats_left <= beats_left - 1'b1;
                  if (last_beat) state <= ST_IDLE;
                  else if (pkt_end) state <= ST_READ_HEADER;
               end else if (flit_taken && pkt_end) begin
                  state <= ST_READ_HEADER;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/mam_top.sv
/*
 * Debug memory access top level
 *   control FSM with request capture, write gather
 *   and packet emitter around it
 */
`timescale 1ns/100ps
`default_nettype none

module mam_top
   import mam_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic [15:0]        id,
   input  wire mam_flit_t          in,
   output logic                    in_ready,
   output mam_flit_t               out,
   input  wire logic               out_ready,
   output logic                    req_valid,
   input  wire logic               req_ready,
   output mam_req_t                req,
   output logic                    write_valid,
   output logic [DATA_W-1:0]       write_data,
   input  wire logic               write_ready,
   input  wire logic               write_complete,
   input  wire logic               read_valid,
   input  wire logic [DATA_W-1:0]  read_data,
   output logic                    read_ready
);

   logic        src_load, hdr_load, addr_load, addr_done;
   logic        gather_en, word_full;
   logic        flit_taken, word_taken, pkt_end;
   logic        last_beat;
   mam_emit_e   mode;
   logic [15:0] di_src;

   mam_ctrl u_ctrl (
      .clk, .rst,
      .in_valid (in.valid),
      .in_last  (in.last),
      .in_ready, .req,
      .addr_done, .word_full, .flit_taken, .word_taken, .pkt_end,
      .src_load, .hdr_load, .addr_load, .gather_en,
      .mode, .last_beat,
      .req_valid, .req_ready,
      .write_valid, .write_ready, .write_complete,
      .read_valid, .read_ready
   );

   mam_req_capture u_capture (
      .clk, .rst, .in,
      .src_load, .hdr_load, .addr_load,
      .req, .di_src, .addr_done
   );

   mam_write_gather u_gather (
      .clk, .rst, .in,
      .gather_en, .write_data, .word_full
   );

   mam_read_emitter u_emitter (
      .clk, .rst, .mode, .di_src, .id, .read_data, .last_beat,
      .out_ready, .out, .flit_taken, .word_taken, .pkt_end
   );

endmodule

`default_nettype wire

// File: sim/mam_properties.sv
/*
 * Concurrent checks on the debug memory access top level
 *   idle handshakes after reset
 *   request and output flit held stable under back-pressure
 *   read_ready only with read_valid
 */
`timescale 1ns/100ps
`default_nettype none

module mam_properties
   import mam_pkg::*;
(
   input wire logic      clk,
   input wire logic      rst,
   input wire logic      req_valid,
   input wire logic      req_ready,
   input wire mam_req_t  req,
   input wire logic      write_valid,
   input wire mam_flit_t out,
   input wire logic      out_ready,
   input wire logic      read_valid,
   input wire logic      read_ready
);

   reset_idle: assert property (@(posedge clk) rst |=> !req_valid && !write_valid && !out.valid)
      else $error("handshakes active after reset");

   req_hold: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid && $stable(req))
      else $error("request changed before req_ready");

   out_hold: assert property (@(posedge clk) disable iff (rst)
      out.valid && !out_ready |=> out.valid && $stable(out))
      else $error("output flit changed while stalled");

   read_ack: assert property (@(posedge clk) disable iff (rst) read_ready |-> read_valid)
      else $error("read_ready without read_valid");

endmodule

bind mam_top mam_properties u_props (.*);

`default_nettype wire

// File: sim/mam_tb.sv
/*
 * Testbench for the debug memory access module
 *   clock, reset and random handshake stalls
 *   sparse memory model with sync write completion
 *   request packet driver fed from the testdata file
 *   checker for memory requests, write beats and output packets
 */
`timescale 1ns/100ps
`default_nettype none

module mam_tb
   import mam_pkg::*;
();

   localparam logic [15:0] SRC_ID      = 16'h0abc;
   localparam logic [15:0] DUT_ID      = 16'h0d1d;
   localparam logic [15:0] FLAGS_EVENT = 16'h8000; // Event type, subtype 0
   localparam int PKT_FLITS   = 4;                  // Data flits per response packet
   localparam int TIMEOUT     = 2000;
   localparam int MAX_ENTRIES = 6 * 32;

   logic        clk, rst, in_ready, out_ready, req_valid, req_ready;
   logic        write_valid, write_ready, write_complete, read_valid, read_ready;
   logic [15:0] id;
   logic [31:0] write_data, read_data;
   mam_flit_t   in, out;
   mam_req_t    req;

   logic [31:0] tdata [0:MAX_ENTRIES-1];
   logic [31:0] mem [logic [29:0]];   // Keyed by word address
   logic [16:0] exp_q [$];            // {last, data} of expected output flits
   logic [31:0] wdata [$];
   integer      stall_seed = 32'h723d;
   integer      data_seed = 32'h723d;
   logic        cur_we, cur_burst, cur_sync;
   logic [7:0]  cur_cnt;
   logic [31:0] cur_addr;
   logic [29:0] rd_key, wr_key;
   int          cur_beats, wr_idx = 0, rd_left = 0, cmpl_cnt = 0;
   logic        req_seen = 1'b0, sync_pending = 1'b0, cmpl_arm = 1'b0, rd_hold = 1'b0;

   mam_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic fail_msg(input string what);
      $display("%s at %0t ns", what, $time);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   // Unwritten words read back as the inverted byte address
   function automatic logic [31:0] mem_word(input logic [29:0] key);
      return mem.exists(key) ? mem[key] : ~{key, 2'b00};
   endfunction

   function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] strb);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[8*b +: 8] = nw[8*b +: 8];
      end
      return res;
   endfunction

   task automatic push_header(input logic last);
      exp_q.push_back({1'b0, SRC_ID});
      exp_q.push_back({1'b0, DUT_ID});
      exp_q.push_back({last, FLAGS_EVENT});
   endtask

   task automatic push_read_stream();
      logic [31:0] word;
      logic        last;
      int          dc;
      dc = 0;
      for (int i = 0; i < cur_beats; i++) begin
         word = mem_word(cur_addr[31:2] + 30'(i));
         for (int h = 0; h < 2; h++) begin
            if (dc == 0) push_header(1'b0);
            last = (dc == PKT_FLITS - 1) || (i == cur_beats - 1 && h == 1);
            exp_q.push_back({last, word[31 - 16*h -: 16]}); // Upper half first
            dc = last ? 0 : dc + 1;
         end
      end
   endtask

   // Memory side and output checker
   always @(posedge clk) begin
      if (!rst) begin
         if (req_valid && req_ready) begin
            check("req.we", req.we, cur_we);
            check("req.burst", req.burst, cur_burst);
            check("req.sync", req.sync, cur_sync);
            check("req.addr", req.addr, cur_addr);
            check("req.beats", req.beats, cur_beats);
            check("req.strb", req.strb, cur_cnt[3:0]);
            req_seen = 1'b1;
            rd_key = cur_addr[31:2];
            if (!cur_we) begin
               rd_left = cur_beats;
               push_read_stream();
            end
         end
         if (write_valid && write_ready) begin
            if (!cur_we || wr_idx >= cur_beats) fail_msg("Write beat that was not requested");
            check("write_data", write_data, wdata[wr_idx]);
            check("req.addr during write", req.addr, cur_addr);
            wr_key = cur_addr[31:2] + 30'(wr_idx);
            mem[wr_key] = cur_burst ? write_data
                                    : merge_word(mem_word(wr_key), write_data, cur_cnt[3:0]);
            wr_idx++;
            if (wr_idx == cur_beats && cur_sync) cmpl_arm = 1'b1;
         end
         if (read_ready) begin
            check("read_valid at read_ready", read_valid, 1'b1);
            rd_key++;
            rd_left--;
            rd_hold = 1'b0;
         end
         if (out.valid && out_ready) begin
            if (exp_q.size() == 0) fail_msg("Output flit appeared when none was expected");
            check("output flit {last,data}", {out.last, out.data}, exp_q.pop_front());
         end
      end
   end

   // Random stalls and sync completion, driven on the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         req_ready   = ($random(stall_seed) & 3) != 0;
         write_ready = ($random(stall_seed) & 3) != 0;
         out_ready   = ($random(stall_seed) & 1) != 0;
         if (rd_left > 0 && (rd_hold || ($random(stall_seed) & 1))) begin
            read_valid = 1'b1;   // Held until the word is taken
            read_data  = mem_word(rd_key);
            rd_hold    = 1'b1;
         end else begin
            read_valid = 1'b0;
         end
         if (req_valid) write_complete = 1'b0;
         if (cmpl_arm) begin
            cmpl_cnt = 1 + ($random(stall_seed) & 7);
            cmpl_arm = 1'b0;
         end else if (cmpl_cnt > 0) begin
            cmpl_cnt--;
            if (cmpl_cnt == 0) begin
               write_complete = 1'b1;
               push_header(1'b1);    // Acknowledge expected only from now on
               sync_pending = 1'b0;
            end
         end
      end
   end

   task automatic send_flit(input logic [15:0] data, input logic last);
      int t;
      in.valid = 1'b1;
      in.last  = last;
      in.data  = data;
      t = 0;
      while (!in_ready) begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) fail_msg("Timeout: the DUT did not accept an input flit");
      end
      @(negedge clk);
      in = '0;
   endtask

   task automatic send_word(input logic [31:0] w, input logic last);
      send_flit(w[31:16], 1'b0);
      send_flit(w[15:0], last);
   endtask

   task automatic send_header();
      send_flit(16'h0000, 1'b0);  // Destination
      send_flit(SRC_ID, 1'b0);
      send_flit(16'h0000, 1'b0);  // Flags
   endtask

   task automatic wait_done();
      int t;
      t = 0;
      while (!(req_seen && (!cur_we || wr_idx == cur_beats) && rd_left == 0 && !sync_pending
               && exp_q.size() == 0)) begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) fail_msg("Timeout: a transaction did not complete");
      end
   endtask

   task automatic run_txn(input int base);
      logic [31:0] w;
      int          first, sent, n;
      cur_we    = tdata[base][0];
      cur_burst = tdata[base+1][0];
      cur_sync  = tdata[base+2][0];
      cur_cnt   = tdata[base+3][7:0];
      cur_addr  = tdata[base+4];
      cur_beats = cur_burst ? int'(cur_cnt) : 1;
      wdata.delete();
      w = tdata[base+5];
      for (int i = 0; i < cur_beats; i++) begin
         wdata.push_back(w);
         w = w + $random(data_seed);
      end
      wr_idx       = 0;
      req_seen     = 1'b0;
      sync_pending = cur_sync;
      send_header();
      send_flit({cur_we, cur_burst, cur_sync, 5'b0, cur_cnt}, 1'b0);
      send_flit(cur_addr[31:16], 1'b0);
      if (!cur_we) begin
         send_flit(cur_addr[15:0], 1'b1);
      end else begin
         first = 1;
         if (cur_burst) first = ($random(data_seed) & 1) ? 0 : ((cur_beats < 2) ? cur_beats : 2);
         send_flit(cur_addr[15:0], first == 0);
         for (int i = 0; i < first; i++) send_word(wdata[i], i == first - 1);
         sent = first;
         while (sent < cur_beats) begin  // Continuation packets
            send_header();
            n = (cur_beats - sent < 3) ? cur_beats - sent : 3;
            for (int j = 0; j < n; j++) send_word(wdata[sent + j], j == n - 1);
            sent += n;
         end
      end
      wait_done();
   endtask

   initial begin
      int base;
      rst            = 1'b1;
      in             = '0;
      id             = DUT_ID;
      out_ready      = 1'b0;
      req_ready      = 1'b0;
      write_ready    = 1'b0;
      write_complete = 1'b0;
      read_valid     = 1'b0;
      read_data      = '0;
      $readmemh("sim/mam_testdata.hex", tdata);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst  = 1'b0;
      base = 0;
      while (base + 6 <= MAX_ENTRIES && tdata[base] != 32'hff) begin
         run_txn(base);
         base += 6;
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/mam_testdata.hex
// Columns: we burst sync count addr first_word
// count is the beat count for bursts, the byte strobe for single accesses
1 0 0 0f 00000100 deadbeef
1 0 0 05 00000104 12345678
0 1 0 02 00000100 00000000
1 1 0 05 00000200 a5a50001
0 1 0 05 00000200 00000000
1 0 1 0f 00000300 cafe0001
1 1 1 03 00000310 01020304
0 1 0 06 00000300 00000000
0 0 0 01 00000500 00000000
1 1 0 07 00000400 11110000
0 1 0 08 000003fc 00000000
0 0 0 0f 00000104 00000000
1 1 1 06 00000600 76543210
0 1 0 03 00000600 00000000
// End marker
ff 0 0 0 0 0

// File: mam_top.f
logic/mam_pkg.sv
logic/mam_req_capture.sv
logic/mam_write_gather.sv
logic/mam_read_emitter.sv
logic/mam_ctrl.sv
logic/mam_top.sv
sim/mam_properties.sv
sim/mam_tb.sv

// File: Makefile
# Verilator build and run for the debug memory access module

VERILATOR ?= verilator
TOP       ?= mam_tb
RTL_TOP   ?= mam_top
FLIST     ?= mam_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
